// ==== design/pdh_pkg.sv ====
package pdh_pkg;

    //////////////////// Host command word

    typedef enum logic [3:0] {
        CMD_IDLE              = 4'd0,
        CMD_SET_LED           = 4'd1,
        CMD_SET_DAC           = 4'd2,
        CMD_GET_ADC           = 4'd3,
        CMD_CHECK_SIGNED      = 4'd4,
        CMD_SET_ROT_COEFFS    = 4'd5,
        CMD_COMMIT_ROT_COEFFS = 4'd6,
        CMD_GET_FRAME         = 4'd7
    } cmd_t;

    localparam int GPIO_WIDTH = 32; // Command and callback words
    localparam int CMD_MSB    = 29;
    localparam int CMD_LSB    = 26;
    localparam int STROBE_BIT = 30;
    localparam int DATA_WIDTH = 26; // Payload in bits 25..0

    //////////////////// Datapath

    typedef logic signed [15:0] sample_t;

    localparam sample_t COEFF_ONE = 16'sh7FFF; // Close to +1.0 in Q1.15
    localparam int ADC_OFFSET     = 8192;       // Offset-binary midpoint

    //////////////////// Reset and default values

    localparam logic [DATA_WIDTH-1:0] DEC_RESET = 26'd1;
    localparam logic [13:0] DAC_MID             = 14'h2000;

    // Readback selector for CHECK_SIGNED
    localparam int SEL_WIDTH = 5;

endpackage

// ==== design/pdh_cmd_capture.sv ====
`timescale 1ns/10ps

module pdh_cmd_capture import pdh_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [GPIO_WIDTH-1:0] gpio_i,
    output cmd_t                  cmd_o,
    output logic [DATA_WIDTH-1:0] data_o
);

    logic strobe_meta_r;
    logic strobe_sync_r;
    logic strobe_prev_r;
    logic strobe_edge_w;

    // Bits 31 and 30 are not part of the command
    logic [CMD_MSB:0] word_r;

    //////////////////// Strobe sync and edge

    assign strobe_edge_w = strobe_sync_r & ~strobe_prev_r;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            strobe_meta_r <= 1'b0;
            strobe_sync_r <= 1'b0;
            strobe_prev_r <= 1'b0;
        end else begin
            strobe_meta_r <= gpio_i[STROBE_BIT];
            strobe_sync_r <= strobe_meta_r;
            strobe_prev_r <= strobe_sync_r;
        end
    end

    //////////////////// Command word register

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            word_r <= '0;
        end else if (strobe_edge_w) begin
            word_r <= gpio_i[CMD_MSB:0]; // Host holds the word until next strobe
        end
    end

    assign cmd_o  = cmd_t'(word_r[CMD_MSB:CMD_LSB]);
    assign data_o = word_r[DATA_WIDTH-1:0];

endmodule

// ==== design/pdh_adc_condition.sv ====
`timescale 1ns/10ps

module pdh_adc_condition import pdh_pkg::*; #(
    parameter int ADC_DATA_WIDTH = 14
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic [ADC_DATA_WIDTH-1:0] adc_a_i,
    input  logic [ADC_DATA_WIDTH-1:0] adc_b_i,
    output sample_t                   adc_a_s_o,
    output sample_t                   adc_b_s_o
);

    // Offset-binary to signed, with the front end's inversion undone
    function automatic sample_t to_signed(input logic [ADC_DATA_WIDTH-1:0] raw);
        logic signed [ADC_DATA_WIDTH:0] diff;
        diff = $signed({1'b0, raw}) - (ADC_DATA_WIDTH+1)'(ADC_OFFSET);
        diff = -diff;
        return sample_t'(diff); // Sign extend
    endfunction

    sample_t adc_a_s_w;
    sample_t adc_b_s_w;

    assign adc_a_s_w = to_signed(adc_a_i);
    assign adc_b_s_w = to_signed(adc_b_i);

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            adc_a_s_o <= '0;
            adc_b_s_o <= '0;
        end else begin
            adc_a_s_o <= adc_a_s_w;
            adc_b_s_o <= adc_b_s_w;
        end
    end

endmodule

// ==== design/pdh_iq_rotator.sv ====
`timescale 1ns/10ps

module pdh_iq_rotator import pdh_pkg::*; (
    input  logic    clk,
    input  logic    rst_i,
    input  sample_t adc_a_s_i,
    input  sample_t adc_b_s_i,
    input  sample_t rot_cos_i,
    input  sample_t rot_sin_i,
    output sample_t i_o,
    output sample_t q_o
);

    logic signed [31:0] i_full_w;
    logic signed [31:0] q_full_w;
    logic signed [31:0] i_shift_w;
    logic signed [31:0] q_shift_w;

    //////////////////// Rotation

    // I = cos*a - sin*b, Q = sin*a + cos*b
    always_comb begin
        i_full_w = rot_cos_i * adc_a_s_i - rot_sin_i * adc_b_s_i;
        q_full_w = rot_sin_i * adc_a_s_i + rot_cos_i * adc_b_s_i;
    end

    // Back to Q1.15 scale
    assign i_shift_w = i_full_w >>> 15;
    assign q_shift_w = q_full_w >>> 15;

    //////////////////// Output register

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            i_o <= '0;
            q_o <= '0;
        end else begin
            i_o <= i_shift_w[15:0]; // Truncate, no saturation
            q_o <= q_shift_w[15:0];
        end
    end

endmodule

// ==== design/pdh_cmd_exec.sv ====
`timescale 1ns/10ps

module pdh_cmd_exec import pdh_pkg::*; #(
    parameter int ADC_DATA_WIDTH = 14,
    parameter int DAC_DATA_WIDTH = 14
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  cmd_t                      cmd_i,
    input  logic [DATA_WIDTH-1:0]     data_i,
    input  logic [ADC_DATA_WIDTH-1:0] adc_a_i,
    input  logic [ADC_DATA_WIDTH-1:0] adc_b_i,
    input  sample_t                   adc_a_s_i,
    input  sample_t                   adc_b_s_i,
    input  sample_t                   i_i,
    input  sample_t                   q_i,
    input  logic                      dma_finished_i,
    input  logic                      dma_engaged_i,
    output logic [GPIO_WIDTH-1:0]     gpio_o,
    output logic [7:0]                led_o,
    output logic [DAC_DATA_WIDTH-1:0] dac_dat_o,
    output logic                      dac_wrt_o,
    output logic                      dac_sel_o,
    output sample_t                   rot_cos_o,
    output sample_t                   rot_sin_o,
    output sample_t                   cos_o,
    output sample_t                   sin_o,
    output logic [DATA_WIDTH-1:0]     dma_decimation_code_o
);

    logic dma_finished_r;
    logic dma_engaged_r;

    logic [7:0]                next_led_w;
    logic [DAC_DATA_WIDTH-1:0] next_dac_dat_w;
    logic                      next_dac_wrt_w;
    logic                      next_dac_sel_w;
    sample_t                   next_cos_w;
    sample_t                   next_sin_w;
    sample_t                   next_rot_cos_w;
    sample_t                   next_rot_sin_w;
    logic [DATA_WIDTH-1:0]     next_dec_w;
    logic [GPIO_WIDTH-1:0]     next_cb_w;

    logic [SEL_WIDTH-1:0]      sel_w;
    sample_t                   sel_val_w;

    //////////////////// Settings update

    always_comb begin
        next_led_w     = led_o;
        next_dac_dat_w = dac_dat_o;
        next_dac_wrt_w = dac_wrt_o;
        next_dac_sel_w = dac_sel_o;
        next_cos_w     = cos_o;
        next_sin_w     = sin_o;
        next_rot_cos_w = rot_cos_o;
        next_rot_sin_w = rot_sin_o;
        next_dec_w     = dma_decimation_code_o;
        case (cmd_i)
            CMD_SET_LED: next_led_w = data_i[7:0];
            CMD_SET_DAC: begin
                next_dac_wrt_w = data_i[15];
                next_dac_sel_w = data_i[14];
                next_dac_dat_w = data_i[DAC_DATA_WIDTH-1:0];
            end
            CMD_SET_ROT_COEFFS: begin
                if (data_i[16]) next_sin_w = data_i[15:0];
                else            next_cos_w = data_i[15:0];
            end
            CMD_COMMIT_ROT_COEFFS: begin
                next_rot_cos_w = cos_o;
                next_rot_sin_w = sin_o;
            end
            CMD_GET_FRAME: next_dec_w = data_i;
            CMD_IDLE, CMD_GET_ADC, CMD_CHECK_SIGNED: begin
                // Read-only, state holds
            end
            default: begin
                next_led_w     = '0;
                next_dac_dat_w = DAC_DATA_WIDTH'(DAC_MID); // Park DAC at midscale
                next_dac_wrt_w = 1'b0;
                next_dac_sel_w = 1'b0;
                next_cos_w     = COEFF_ONE;
                next_sin_w     = '0;
                next_rot_cos_w = COEFF_ONE;
                next_rot_sin_w = '0;
                next_dec_w     = DEC_RESET;
            end
        endcase
    end

    //////////////////// Readback

    assign sel_w = data_i[SEL_WIDTH-1:0];

    always_comb begin
        case (sel_w)
            5'd0:    sel_val_w = adc_a_s_i;
            5'd1:    sel_val_w = adc_b_s_i;
            5'd2:    sel_val_w = cos_o;
            5'd3:    sel_val_w = sin_o;
            5'd4:    sel_val_w = rot_cos_o;
            5'd5:    sel_val_w = rot_sin_o;
            5'd6:    sel_val_w = i_i;
            5'd7:    sel_val_w = q_i;
            5'd8:    sel_val_w = {15'd0, dma_finished_r};
            5'd9:    sel_val_w = {15'd0, dma_engaged_r};
            default: sel_val_w = '0;
        endcase
    end

    always_comb begin
        next_cb_w = '0;
        next_cb_w[GPIO_WIDTH-1 -: $bits(cmd_t)] = cmd_i; // Echo command code
        case (cmd_i)
            CMD_SET_LED:      next_cb_w[7:0] = led_o;
            CMD_SET_DAC:      next_cb_w[DAC_DATA_WIDTH+1:0] = {dac_wrt_o, dac_sel_o, dac_dat_o};
            CMD_GET_ADC:      next_cb_w[2*ADC_DATA_WIDTH-1:0] = {adc_b_i, adc_a_i};
            CMD_CHECK_SIGNED: begin
                next_cb_w[16 +: SEL_WIDTH] = sel_w;
                next_cb_w[15:0]            = sel_val_w;
            end
            CMD_SET_ROT_COEFFS:    next_cb_w[27:0] = {sin_o[15:2], cos_o[15:2]};
            CMD_COMMIT_ROT_COEFFS: next_cb_w[27:0] = {q_i[15:2], i_i[15:2]};
            CMD_GET_FRAME: begin
                next_cb_w[27:0] = {1'b0, dma_decimation_code_o, dma_engaged_r};
            end
            default: next_cb_w = '0; // IDLE and unknown codes
        endcase
    end

    //////////////////// Registers

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            dma_finished_r        <= 1'b0;
            dma_engaged_r         <= 1'b0;
            led_o                 <= '0;
            dac_dat_o             <= '0;
            dac_wrt_o             <= 1'b0;
            dac_sel_o             <= 1'b0;
            cos_o                 <= COEFF_ONE;
            sin_o                 <= '0;
            rot_cos_o             <= COEFF_ONE;
            rot_sin_o             <= '0;
            dma_decimation_code_o <= DEC_RESET;
            gpio_o                <= '0;
        end else begin
            dma_finished_r        <= dma_finished_i;
            dma_engaged_r         <= dma_engaged_i;
            led_o                 <= next_led_w;
            dac_dat_o             <= next_dac_dat_w;
            dac_wrt_o             <= next_dac_wrt_w;
            dac_sel_o             <= next_dac_sel_w;
            cos_o                 <= next_cos_w;
            sin_o                 <= next_sin_w;
            rot_cos_o             <= next_rot_cos_w;
            rot_sin_o             <= next_rot_sin_w;
            dma_decimation_code_o <= next_dec_w;
            gpio_o                <= next_cb_w;
        end
    end

endmodule

// ==== design/pdh_core.sv ====
`timescale 1ns/10ps

module pdh_core import pdh_pkg::*; #(
    parameter int ADC_DATA_WIDTH = 14,
    parameter int DAC_DATA_WIDTH = 14
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic [GPIO_WIDTH-1:0]     gpio_i,
    input  logic [ADC_DATA_WIDTH-1:0] adc_a_i,
    input  logic [ADC_DATA_WIDTH-1:0] adc_b_i,
    input  logic                      dma_finished_i,
    input  logic                      dma_engaged_i,
    output logic [GPIO_WIDTH-1:0]     gpio_o,
    output logic [7:0]                led_o,
    output logic [DAC_DATA_WIDTH-1:0] dac_dat_o,
    output logic                      dac_wrt_o,
    output logic                      dac_sel_o,
    output logic                      dma_enable_o,
    output logic [63:0]               dma_data_o,
    output logic [DATA_WIDTH-1:0]     dma_decimation_code_o
);

    cmd_t                  cmd_w;
    logic [DATA_WIDTH-1:0] data_w;
    sample_t               adc_a_s_w;
    sample_t               adc_b_s_w;
    sample_t               rot_cos_w;
    sample_t               rot_sin_w;
    sample_t               cos_w;     // Staged
    sample_t               sin_w;
    sample_t               i_w;
    sample_t               q_w;

    //////////////////// Host side

    pdh_cmd_capture u_capture (
        .clk    (clk),
        .rst_i  (rst_i),
        .gpio_i (gpio_i),
        .cmd_o  (cmd_w),
        .data_o (data_w)
    );

    pdh_cmd_exec #(
        .ADC_DATA_WIDTH (ADC_DATA_WIDTH),
        .DAC_DATA_WIDTH (DAC_DATA_WIDTH)
    ) u_exec (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .cmd_i                 (cmd_w),
        .data_i                (data_w),
        .adc_a_i               (adc_a_i),
        .adc_b_i               (adc_b_i),
        .adc_a_s_i             (adc_a_s_w),
        .adc_b_s_i             (adc_b_s_w),
        .i_i                   (i_w),
        .q_i                   (q_w),
        .dma_finished_i        (dma_finished_i),
        .dma_engaged_i         (dma_engaged_i),
        .gpio_o                (gpio_o),
        .led_o                 (led_o),
        .dac_dat_o             (dac_dat_o),
        .dac_wrt_o             (dac_wrt_o),
        .dac_sel_o             (dac_sel_o),
        .rot_cos_o             (rot_cos_w),
        .rot_sin_o             (rot_sin_w),
        .cos_o                 (cos_w),
        .sin_o                 (sin_w),
        .dma_decimation_code_o (dma_decimation_code_o)
    );

    //////////////////// ADC datapath

    pdh_adc_condition #(
        .ADC_DATA_WIDTH (ADC_DATA_WIDTH)
    ) u_condition (
        .clk       (clk),
        .rst_i     (rst_i),
        .adc_a_i   (adc_a_i),
        .adc_b_i   (adc_b_i),
        .adc_a_s_o (adc_a_s_w),
        .adc_b_s_o (adc_b_s_w)
    );

    pdh_iq_rotator u_rotator (
        .clk       (clk),
        .rst_i     (rst_i),
        .adc_a_s_i (adc_a_s_w),
        .adc_b_s_i (adc_b_s_w),
        .rot_cos_i (rot_cos_w),
        .rot_sin_i (rot_sin_w),
        .i_o       (i_w),
        .q_o       (q_w)
    );

    //////////////////// DMA

    assign dma_enable_o = (cmd_w == CMD_GET_FRAME); // Streams while GET_FRAME is in force
    assign dma_data_o   = {i_w, q_w, cos_w, sin_w};

endmodule

// ==== verification/pdh_core_tb.sv ====
`timescale 1ns/10ps

module pdh_core_tb import pdh_pkg::*; ();

    localparam int ADC_DATA_WIDTH = 14;
    localparam int DAC_DATA_WIDTH = 14;
    localparam int MAX_TESTS      = 64;
    localparam int WORDS_PER_TEST = 8; // Columns per line of the test file
    localparam int SETTLE_CYCLES  = 8;

    logic                      clk;
    logic                      rst_i;
    logic [GPIO_WIDTH-1:0]     gpio_i;
    logic [ADC_DATA_WIDTH-1:0] adc_a_i;
    logic [ADC_DATA_WIDTH-1:0] adc_b_i;
    logic                      dma_finished_i;
    logic                      dma_engaged_i;
    logic [GPIO_WIDTH-1:0]     gpio_o;
    logic [7:0]                led_o;
    logic [DAC_DATA_WIDTH-1:0] dac_dat_o;
    logic                      dac_wrt_o;
    logic                      dac_sel_o;
    logic                      dma_enable_o;
    logic [63:0]               dma_data_o;
    logic [DATA_WIDTH-1:0]     dma_decimation_code_o;

    logic [31:0] test_mem [0:MAX_TESTS*WORDS_PER_TEST-1];
    int          num_tests;
    int          pass_count;
    int          fail_count;
    int          test_errors;
    int          cycle_count = 0;
    int          cycle_limit;

    // Expected coefficient and decimation state
    sample_t               exp_cos;     // Staged
    sample_t               exp_sin;
    sample_t               exp_rot_cos; // Committed
    sample_t               exp_rot_sin;
    logic [DATA_WIDTH-1:0] exp_dec;

    pdh_core #(
        .ADC_DATA_WIDTH (ADC_DATA_WIDTH),
        .DAC_DATA_WIDTH (DAC_DATA_WIDTH)
    ) dut_i (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .gpio_i                (gpio_i),
        .adc_a_i               (adc_a_i),
        .adc_b_i               (adc_b_i),
        .dma_finished_i        (dma_finished_i),
        .dma_engaged_i         (dma_engaged_i),
        .gpio_o                (gpio_o),
        .led_o                 (led_o),
        .dac_dat_o             (dac_dat_o),
        .dac_wrt_o             (dac_wrt_o),
        .dac_sel_o             (dac_sel_o),
        .dma_enable_o          (dma_enable_o),
        .dma_data_o            (dma_data_o),
        .dma_decimation_code_o (dma_decimation_code_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////// Checks

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            test_errors++;
        end
    endtask

    //////////////////// Reference model

    // Offset-binary sample minus midpoint, then inverted
    function automatic sample_t adc_to_signed(input logic [ADC_DATA_WIDTH-1:0] raw);
        int value;
        value = ADC_OFFSET - int'(raw);
        return sample_t'(value);
    endfunction

    // Q1.15 rotation, result is {I, Q}
    function automatic logic [31:0] rotate_iq(input sample_t c, input sample_t s,
                                              input sample_t a, input sample_t b);
        int i_full;
        int q_full;
        i_full = int'(c) * int'(a) - int'(s) * int'(b);
        q_full = int'(s) * int'(a) + int'(c) * int'(b);
        return {16'(i_full >>> 15), 16'(q_full >>> 15)};
    endfunction

    task automatic update_model(input logic [31:0] word);
        logic [3:0] code;
        code = word[CMD_MSB:CMD_LSB];
        if (code >= 4'd8) begin
            exp_cos     = COEFF_ONE; // Dropped codes restore reset values
            exp_sin     = '0;
            exp_rot_cos = COEFF_ONE;
            exp_rot_sin = '0;
            exp_dec     = DEC_RESET;
        end else if (code == CMD_SET_ROT_COEFFS) begin
            if (word[16]) begin
                exp_sin = word[15:0];
            end else begin
                exp_cos = word[15:0];
            end
        end else if (code == CMD_COMMIT_ROT_COEFFS) begin
            exp_rot_cos = exp_cos;
            exp_rot_sin = exp_sin;
        end else if (code == CMD_GET_FRAME) begin
            exp_dec = word[DATA_WIDTH-1:0];
        end
    endtask

    // One host transaction with the strobe a cycle after the word
    task automatic run_test(input int idx);
        int          base;
        logic [31:0] word;
        logic [1:0]  flags;
        base  = idx * WORDS_PER_TEST;
        word  = test_mem[base];
        flags = test_mem[base + 3][1:0];
        test_errors = 0;
        update_model(word);

        gpio_i             = word;
        gpio_i[STROBE_BIT] = 1'b0;
        adc_a_i            = test_mem[base + 1][ADC_DATA_WIDTH-1:0];
        adc_b_i            = test_mem[base + 2][ADC_DATA_WIDTH-1:0];
        dma_finished_i     = flags[1];
        dma_engaged_i      = flags[0];
        @(posedge clk);
        #5;
        gpio_i[STROBE_BIT] = 1'b1;

        repeat (SETTLE_CYCLES) @(posedge clk);
        #5;
        check("gpio_o", gpio_o, test_mem[base + 4]);
        check("led_o", {24'd0, led_o}, test_mem[base + 5]);
        check("dac", {16'd0, dac_wrt_o, dac_sel_o, dac_dat_o}, test_mem[base + 6]);
        check("dma_enable_o", {31'd0, dma_enable_o}, test_mem[base + 7]);
        check("dma_decimation_code_o", {6'd0, dma_decimation_code_o}, {6'd0, exp_dec});
        check("dma_data_o[63:32]", dma_data_o[63:32],
              rotate_iq(exp_rot_cos, exp_rot_sin, adc_to_signed(adc_a_i),
                        adc_to_signed(adc_b_i)));
        check("dma_data_o[31:0]", dma_data_o[31:0], {exp_cos, exp_sin});
        gpio_i[STROBE_BIT] = 1'b0;

        if (test_errors == 0) begin
            pass_count++;
            $display("Test %0d word 0x%h ok", idx, word);
        end else begin
            fail_count++;
            $display("Test %0d word 0x%h had %0d mismatches", idx, word, test_errors);
        end
        @(posedge clk); // Let the strobe low reach the sync flops
        #5;
    endtask

    //////////////////// Main sequence

    initial begin
        rst_i          = 1'b1;
        gpio_i         = '0;
        adc_a_i        = '0;
        adc_b_i        = '0;
        dma_finished_i = 1'b0;
        dma_engaged_i  = 1'b0;
        pass_count     = 0;
        fail_count     = 0;
        exp_cos        = COEFF_ONE;
        exp_sin        = '0;
        exp_rot_cos    = COEFF_ONE;
        exp_rot_sin    = '0;
        exp_dec        = DEC_RESET;

        // All ones marks the end of the loaded tests
        for (int i = 0; i < MAX_TESTS*WORDS_PER_TEST; i++) begin
            test_mem[i] = '1;
        end
        $readmemh("verification/pdh_core_tests.txt", test_mem);
        num_tests = 0;
        while (num_tests < MAX_TESTS && test_mem[num_tests*WORDS_PER_TEST] != '1) begin
            num_tests++;
        end
        cycle_limit = 12*num_tests + 50;

        repeat (2) @(posedge clk);
        #5;
        rst_i = 1'b0;

        if (num_tests == 0) begin
            $display("No tests were loaded from the test file");
            fail_count++;
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verification/pdh_core_tests.txt ====
// cmd_word adc_a adc_b dma_flags(bit1 finished, bit0 engaged)
// exp_gpio_o exp_led_o exp_dac(wrt, sel, dat[13:0]) exp_dma_enable_o
840000A5 2000 2000 0 100000A5 A5 0000 0
08009234 2000 2000 0 20009234 A5 9234 0
08007FFF 2000 2000 0 20007FFF A5 7FFF 0
0C000000 1ABC 0123 0 3048DABC A5 7FFF 0
10000000 1ABC 0123 0 40000544 A5 7FFF 0
10000001 1ABC 0123 0 40011EDD A5 7FFF 0
10000000 3000 0123 0 4000F000 A5 7FFF 0
14004000 1000 3000 0 50001000 A5 7FFF 0
1401E000 1000 3000 0 5E001000 A5 7FFF 0
10000002 1000 3000 0 40024000 A5 7FFF 0
10000003 1000 3000 0 4003E000 A5 7FFF 0
10000004 1000 3000 0 40047FFF A5 7FFF 0
10000005 1000 3000 0 40050000 A5 7FFF 0
18000000 1000 3000 0 6F400100 A5 7FFF 0
10000006 1000 3000 0 40060400 A5 7FFF 0
10000007 1000 3000 0 4007F400 A5 7FFF 0
10000005 1000 3000 0 4005E000 A5 7FFF 0
1C000040 1000 3000 1 70000081 A5 7FFF 1
10000008 1000 3000 2 40080001 A5 7FFF 0
10000009 1000 3000 1 40090001 A5 7FFF 0
10000009 1000 3000 2 40090000 A5 7FFF 0
1FFFFFFF 1000 3000 3 77FFFFFF A5 7FFF 1
20000123 1000 3000 0 00000000 00 2000 0
10000002 1000 3000 0 40027FFF 00 2000 0
10000005 1000 3000 0 40050000 00 2000 0
10000003 1000 3000 0 40030000 00 2000 0
00000000 1000 3000 0 00000000 00 2000 0

// ==== pdh_core.f ====
design/pdh_pkg.sv
design/pdh_cmd_capture.sv
design/pdh_adc_condition.sv
design/pdh_iq_rotator.sv
design/pdh_cmd_exec.sv
design/pdh_core.sv
verification/pdh_core_tb.sv

// ==== Makefile ====
TOP = pdh_core_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f pdh_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
		-f pdh_core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
